/* source/fm_pkg.sv */
`default_nettype none

package fm_pkg;

	// Timer block register numbers
	localparam logic [7:0] REG_TA_HIGH = 8'h24;
	localparam logic [7:0] REG_TA_LOW  = 8'h25;
	localparam logic [7:0] REG_TB      = 8'h26;
	localparam logic [7:0] REG_TCTRL   = 8'h27;

	// Bit positions in the timer control register
	localparam int CTRL_LOAD_A    = 0;
	localparam int CTRL_LOAD_B    = 1;
	localparam int CTRL_FLAG_EN_A = 2;
	localparam int CTRL_FLAG_EN_B = 3;
	localparam int CTRL_CLR_A     = 4;
	localparam int CTRL_CLR_B     = 5;

	// Timer A ticks per Timer B tick
	localparam int TB_DIVIDE = 16;

	typedef struct packed {
		logic [7:0] reg_num;
		logic [7:0] data;
	} reg_write_t;

	typedef struct packed {
		logic [9:0] value_a;
		logic [7:0] value_b;
		logic       load_a;
		logic       load_b;
		logic       flag_en_a;
		logic       flag_en_b;
	} timer_cfg_t;

	typedef struct packed {
		logic busy;
		logic flag_b;
		logic flag_a;
	} timer_status_t;

endpackage

`default_nettype wire

/* source/fm_bus_port.sv */
`timescale 1ns/10ps
`default_nettype none

module fm_bus_port (
	input  wire        clk_int,
	input  wire        arst_n,
	input  wire        cs_n,
	input  wire        wr_n,
	input  wire  [1:0] addr,
	input  wire  [7:0] din,
	input  wire        busy,
	input  wire        flag_a,
	input  wire        flag_b,
	output logic       wr_pulse,
	output logic       wr_addr,
	output logic [7:0] wr_data,
	output logic [7:0] dout
);

	logic                  cs_n_q;
	logic                  wr_n_q;
	logic [1:0]            addr_q;
	logic [7:0]            din_q;
	logic                  strobe;
	logic                  strobe_d;
	fm_pkg::timer_status_t status;

	// Bus strobes idle high
	always_ff @(posedge clk_int or negedge arst_n) begin
		if (!arst_n) begin
			cs_n_q   <= 1'b1;
			wr_n_q   <= 1'b1;
			strobe_d <= 1'b0;
		end else begin
			cs_n_q   <= cs_n;
			wr_n_q   <= wr_n;
			strobe_d <= strobe;
		end
	end

	always_ff @(posedge clk_int) begin
		addr_q <= addr;
		din_q  <= din;
	end

	assign strobe = ~cs_n_q & ~wr_n_q;

	// One pulse per strobe low period
	// Upper bank (addr[1] set) has no timer registers
	always_ff @(posedge clk_int or negedge arst_n) begin
		if (!arst_n) begin
			wr_pulse <= 1'b0;
		end else begin
			wr_pulse <= strobe & ~strobe_d & ~addr_q[1];
		end
	end

	always_ff @(posedge clk_int) begin
		wr_addr <= addr_q[0];
		wr_data <= din_q;
	end

	assign status = {busy, flag_b, flag_a};

	// Status byte, busy in bit 7
	always_ff @(posedge clk_int or negedge arst_n) begin
		if (!arst_n) begin
			dout <= 8'h00;
		end else begin
			dout <= {status.busy, 5'b00000, status.flag_b, status.flag_a};
		end
	end

endmodule

`default_nettype wire

/* source/fm_write_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module fm_write_sequencer #(
	parameter int BUSY_CYCLES = 32
) (
	input  wire                clk_int,
	input  wire                arst_n,
	input  wire                wr_pulse,
	input  wire                wr_addr,
	input  wire  [7:0]         wr_data,
	output fm_pkg::reg_write_t reg_write,
	output logic               reg_write_valid,
	output logic               busy
);

	localparam int CNT_W = $clog2(BUSY_CYCLES + 1);

	typedef enum logic {
		ST_IDLE,
		ST_BUSY
	} state_t;

	state_t           state;
	logic [CNT_W-1:0] busy_cnt;
	logic [7:0]       reg_num;
	logic             addr_wr;
	logic             data_wr;
	logic             accept;

	assign addr_wr = wr_pulse & ~wr_addr;
	assign data_wr = wr_pulse & wr_addr;
	assign accept  = data_wr & (state == ST_IDLE);

	// Register select is taken even while busy
	always_ff @(posedge clk_int or negedge arst_n) begin
		if (!arst_n) begin
			reg_num <= 8'h00;
		end else if (addr_wr) begin
			reg_num <= wr_data;
		end
	end

	always_ff @(posedge clk_int or negedge arst_n) begin
		if (!arst_n) begin
			state           <= ST_IDLE;
			busy_cnt        <= '0;
			reg_write_valid <= 1'b0;
		end else begin
			reg_write_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (data_wr) begin
						state           <= ST_BUSY;
						busy_cnt        <= CNT_W'(BUSY_CYCLES - 1);
						reg_write_valid <= 1'b1;
					end
				end
				ST_BUSY: begin
					// Data writes are dropped here
					if (busy_cnt == '0) begin
						state <= ST_IDLE;
					end else begin
						busy_cnt <= busy_cnt - 1'b1;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_int) begin
		if (accept) begin
			reg_write.reg_num <= reg_num;
			reg_write.data    <= wr_data;
		end
	end

	assign busy = (state == ST_BUSY);

endmodule

`default_nettype wire

/* source/fm_reg_map.sv */
`timescale 1ns/10ps
`default_nettype none

module fm_reg_map (
	input  wire fm_pkg::reg_write_t reg_write,
	input  wire                     clk_int,
	input  wire                     arst_n,
	input  wire                     reg_write_valid,
	output fm_pkg::timer_cfg_t      timer_cfg,
	output logic                    clr_flag_a,
	output logic                    clr_flag_b
);

	logic       ctrl_wr;
	logic [7:0] wdata;

	assign wdata   = reg_write.data;
	assign ctrl_wr = reg_write_valid & (reg_write.reg_num == fm_pkg::REG_TCTRL);

	always_ff @(posedge clk_int or negedge arst_n) begin
		if (!arst_n) begin
			timer_cfg <= '0;
		end else if (reg_write_valid) begin
			case (reg_write.reg_num)
				fm_pkg::REG_TA_HIGH: begin
					timer_cfg.value_a[9:2] <= wdata;
				end
				fm_pkg::REG_TA_LOW: begin
					timer_cfg.value_a[1:0] <= wdata[1:0];
				end
				fm_pkg::REG_TB: begin
					timer_cfg.value_b <= wdata;
				end
				fm_pkg::REG_TCTRL: begin
					timer_cfg.load_a    <= wdata[fm_pkg::CTRL_LOAD_A];
					timer_cfg.load_b    <= wdata[fm_pkg::CTRL_LOAD_B];
					timer_cfg.flag_en_a <= wdata[fm_pkg::CTRL_FLAG_EN_A];
					timer_cfg.flag_en_b <= wdata[fm_pkg::CTRL_FLAG_EN_B];
				end
				default: begin
					// Registers of blocks outside the timer section
				end
			endcase
		end
	end

	// Flag resets act once and are not stored
	always_ff @(posedge clk_int or negedge arst_n) begin
		if (!arst_n) begin
			clr_flag_a <= 1'b0;
			clr_flag_b <= 1'b0;
		end else begin
			clr_flag_a <= ctrl_wr & wdata[fm_pkg::CTRL_CLR_A];
			clr_flag_b <= ctrl_wr & wdata[fm_pkg::CTRL_CLR_B];
		end
	end

endmodule

`default_nettype wire

/* source/fm_prescaler.sv */
`timescale 1ns/10ps
`default_nettype none

module fm_prescaler #(
	parameter int PRESCALE = 72
) (
	input  wire  clk_int,
	input  wire  arst_n,
	output logic tick_a,
	output logic tick_b
);

	localparam int CNT_A_W = $clog2(PRESCALE + 1);
	localparam int CNT_B_W = $clog2(fm_pkg::TB_DIVIDE);

	logic [CNT_A_W-1:0] cnt_a;
	logic [CNT_B_W-1:0] cnt_b;
	logic               wrap_a;
	logic               wrap_b;

	assign wrap_a = (cnt_a == CNT_A_W'(PRESCALE - 1));
	assign wrap_b = (cnt_b == CNT_B_W'(fm_pkg::TB_DIVIDE - 1));

	// Free running, never restarted by the timers
	always_ff @(posedge clk_int or negedge arst_n) begin
		if (!arst_n) begin
			cnt_a  <= '0;
			cnt_b  <= '0;
			tick_a <= 1'b0;
			tick_b <= 1'b0;
		end else begin
			tick_a <= wrap_a;
			tick_b <= wrap_a & wrap_b;
			if (wrap_a) begin
				cnt_a <= '0;
				cnt_b <= wrap_b ? '0 : cnt_b + 1'b1;
			end else begin
				cnt_a <= cnt_a + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* source/fm_timers.sv */
`timescale 1ns/10ps
`default_nettype none

module fm_timers (
	input  wire fm_pkg::timer_cfg_t timer_cfg,
	input  wire                     clk_int,
	input  wire                     arst_n,
	input  wire                     clr_flag_a,
	input  wire                     clr_flag_b,
	input  wire                     tick_a,
	input  wire                     tick_b,
	output logic                    flag_a,
	output logic                    flag_b,
	output logic                    irq_n
);

	logic       load_a_d;
	logic       load_b_d;
	logic [9:0] cnt_a;
	logic [7:0] cnt_b;
	logic       start_a;
	logic       start_b;
	logic       ovf_a;
	logic       ovf_b;

	// Rising load bit restarts from the programmed value
	assign start_a = timer_cfg.load_a & ~load_a_d;
	assign start_b = timer_cfg.load_b & ~load_b_d;

	assign ovf_a = ~start_a & timer_cfg.load_a & tick_a & (&cnt_a);
	assign ovf_b = ~start_b & timer_cfg.load_b & tick_b & (&cnt_b);

	// Timer A
	always_ff @(posedge clk_int or negedge arst_n) begin
		if (!arst_n) begin
			load_a_d <= 1'b0;
			cnt_a    <= '0;
		end else begin
			load_a_d <= timer_cfg.load_a;
			if (start_a) begin
				cnt_a <= timer_cfg.value_a;
			end else if (timer_cfg.load_a && tick_a) begin
				cnt_a <= (&cnt_a) ? timer_cfg.value_a : cnt_a + 1'b1;
			end
		end
	end

	// Timer B, ticked once per 16 Timer A ticks
	always_ff @(posedge clk_int or negedge arst_n) begin
		if (!arst_n) begin
			load_b_d <= 1'b0;
			cnt_b    <= '0;
		end else begin
			load_b_d <= timer_cfg.load_b;
			if (start_b) begin
				cnt_b <= timer_cfg.value_b;
			end else if (timer_cfg.load_b && tick_b) begin
				cnt_b <= (&cnt_b) ? timer_cfg.value_b : cnt_b + 1'b1;
			end
		end
	end

	// Clear has priority over a same-cycle overflow
	always_ff @(posedge clk_int or negedge arst_n) begin
		if (!arst_n) begin
			flag_a <= 1'b0;
			flag_b <= 1'b0;
		end else begin
			if (clr_flag_a) begin
				flag_a <= 1'b0;
			end else if (ovf_a && timer_cfg.flag_en_a) begin
				flag_a <= 1'b1;
			end
			if (clr_flag_b) begin
				flag_b <= 1'b0;
			end else if (ovf_b && timer_cfg.flag_en_b) begin
				flag_b <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_int or negedge arst_n) begin
		if (!arst_n) begin
			irq_n <= 1'b1;
		end else begin
			irq_n <= ~(flag_a | flag_b);
		end
	end

endmodule

`default_nettype wire

/* source/fm_timer_core.sv */
`timescale 1ns/10ps
`default_nettype none

module fm_timer_core #(
	parameter int PRESCALE    = 72,
	parameter int BUSY_CYCLES = 32
) (
	input  wire        clk_int,
	input  wire        arst_n,
	input  wire        cs_n,
	input  wire        wr_n,
	input  wire  [1:0] addr,
	input  wire  [7:0] din,
	output logic [7:0] dout,
	output logic       irq_n
);

	logic               wr_pulse;
	logic               wr_addr;
	logic [7:0]         wr_data;
	logic               busy;
	logic               flag_a;
	logic               flag_b;
	logic               reg_write_valid;
	logic               clr_flag_a;
	logic               clr_flag_b;
	logic               tick_a;
	logic               tick_b;
	fm_pkg::reg_write_t reg_write;
	fm_pkg::timer_cfg_t timer_cfg;

	fm_bus_port u_bus_port (
		.clk_int  (clk_int),
		.arst_n   (arst_n),
		.cs_n     (cs_n),
		.wr_n     (wr_n),
		.addr     (addr),
		.din      (din),
		.busy     (busy),
		.flag_a   (flag_a),
		.flag_b   (flag_b),
		.wr_pulse (wr_pulse),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.dout     (dout)
	);

	fm_write_sequencer #(
		.BUSY_CYCLES (BUSY_CYCLES)
	) u_write_sequencer (
		.clk_int         (clk_int),
		.arst_n          (arst_n),
		.wr_pulse        (wr_pulse),
		.wr_addr         (wr_addr),
		.wr_data         (wr_data),
		.reg_write       (reg_write),
		.reg_write_valid (reg_write_valid),
		.busy            (busy)
	);

	fm_reg_map u_reg_map (
		.reg_write       (reg_write),
		.clk_int         (clk_int),
		.arst_n          (arst_n),
		.reg_write_valid (reg_write_valid),
		.timer_cfg       (timer_cfg),
		.clr_flag_a      (clr_flag_a),
		.clr_flag_b      (clr_flag_b)
	);

	fm_prescaler #(
		.PRESCALE (PRESCALE)
	) u_prescaler (
		.clk_int (clk_int),
		.arst_n  (arst_n),
		.tick_a  (tick_a),
		.tick_b  (tick_b)
	);

	fm_timers u_timers (
		.timer_cfg  (timer_cfg),
		.clk_int    (clk_int),
		.arst_n     (arst_n),
		.clr_flag_a (clr_flag_a),
		.clr_flag_b (clr_flag_b),
		.tick_a     (tick_a),
		.tick_b     (tick_b),
		.flag_a     (flag_a),
		.flag_b     (flag_b),
		.irq_n      (irq_n)
	);

endmodule

`default_nettype wire

/* test/fm_timer_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module fm_timer_checker #(
	parameter int PRESCALE    = 72,
	parameter int BUSY_CYCLES = 32
) (
	input  wire        clk_int,
	input  wire        arst_n,
	input  wire        cs_n,
	input  wire        wr_n,
	input  wire  [1:0] addr,
	input  wire  [7:0] dout,
	input  wire        irq_n,
	input  wire  [9:0] value_a,
	input  wire  [7:0] value_b,
	input  wire        mark_a,
	input  wire        mark_b,
	input  wire        flags_off,
	output int         check_count,
	output int         error_count
);

	// Load strobe to first flag on dout, when the tick lands right after the load
	localparam int WRITE_LAT = 6;
	localparam int TICK_A    = PRESCALE;
	localparam int TICK_B    = 16 * PRESCALE;

	int         cycle;
	int         last_a;
	int         last_b;
	logic       armed_a;
	logic       armed_b;
	logic       first_a;
	logic       first_b;
	logic [1:0] flags_q;
	logic       rst_seen;
	logic       strobe_q;
	int         busy_phase;
	int         busy_cnt;

	// Overflow period in clk_int cycles
	function automatic int period_cycles(input logic is_b, input int value);
		if (is_b) begin
			return (256 - value) * 16 * PRESCALE;
		end
		return (1024 - value) * PRESCALE;
	endfunction

	task automatic check_value(input string name, input logic [7:0] got,
			input logic [7:0] expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("** Error: %s = %h, expected %h", name, got, expected);
		end
	endtask

	task automatic check_interval(input string name, input int got, input int expected,
			input int window);
		int diff;
		diff = got - expected;
		check_count++;
		if (diff > window || diff < -window) begin
			error_count++;
			$display("** Error: %s interval = %h, expected %h", name, got, expected);
		end
	endtask

	// Busy must show after an accepted data write and drop again in time
	task automatic track_busy();
		logic strobe;
		strobe = !cs_n && !wr_n && (addr == 2'd1);
		case (busy_phase)
			0: begin
				if (strobe && !strobe_q && !dout[7]) begin
					busy_phase = 1;
					busy_cnt   = 0;
				end
			end
			1: begin
				busy_cnt++;
				if (dout[7]) begin
					check_count++;
					busy_phase = 2;
					busy_cnt   = 0;
				end else if (busy_cnt > 5) begin
					error_count++;
					$display("Busy did not show on dout after a data write");
					busy_phase = 0;
				end
			end
			default: begin
				busy_cnt++;
				if (!dout[7] || busy_cnt > BUSY_CYCLES + 4) begin
					check_count++;
					if (busy_cnt > BUSY_CYCLES + 4) begin
						error_count++;
						$display("** Error: busy high time = %h, limit %h",
							busy_cnt, BUSY_CYCLES + 4);
					end
					busy_phase = 0;
				end
			end
		endcase
		strobe_q = strobe;
	endtask

	initial begin
		check_count = 0;
		error_count = 0;
		cycle       = 0;
	end

	always @(posedge clk_int) begin
		if (!arst_n) begin
			rst_seen   = 1'b0;
			armed_a    = 1'b0;
			armed_b    = 1'b0;
			first_a    = 1'b0;
			first_b    = 1'b0;
			flags_q    = 2'b00;
			strobe_q   = 1'b0;
			busy_phase = 0;
		end else begin
			cycle++;
			if (!rst_seen) begin
				rst_seen = 1'b1;
				check_value("dout", dout, 8'h00);
				check_value("irq_n", irq_n, 8'h01);
			end
			check_value("irq_n", irq_n, {7'b0, ~(dout[1] | dout[0])});
			// Unused status bits stay low
			check_value("dout[6:2]", {3'b0, dout[6:2]}, 8'h00);
			if (flags_off) begin
				check_value("dout[1:0]", {6'b0, dout[1:0]}, 8'h00);
			end
			track_busy();
			if (mark_a) begin
				armed_a = 1'b1;
				first_a = 1'b1;
				last_a  = cycle;
			end
			if (mark_b) begin
				armed_b = 1'b1;
				first_b = 1'b1;
				last_b  = cycle;
			end
			if (dout[0] && !flags_q[0] && armed_a) begin
				check_interval("flag_a", cycle - last_a,
					period_cycles(1'b0, int'(value_a)) + (first_a ? WRITE_LAT : 0),
					first_a ? TICK_A : 0);
				first_a = 1'b0;
				last_a  = cycle;
			end
			if (dout[1] && !flags_q[1] && armed_b) begin
				check_interval("flag_b", cycle - last_b,
					period_cycles(1'b1, int'(value_b)) + (first_b ? WRITE_LAT : 0),
					first_b ? TICK_B : 0);
				first_b = 1'b0;
				last_b  = cycle;
			end
			flags_q = dout[1:0];
		end
	end

endmodule

`default_nettype wire

/* test/fm_timer_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module fm_timer_core_tb;

	localparam int PRESCALE    = 4;
	localparam int BUSY_CYCLES = 8;
	localparam int NUM_TESTS   = 5;
	// Longest Timer B period, reached at value 0
	localparam int TB_PERIOD_MAX = 256 * 16 * PRESCALE;
	localparam int CYCLE_LIMIT   = NUM_TESTS * 2 * TB_PERIOD_MAX + 2000;

	logic        clk_int = 1'b0;
	logic        arst_n;
	logic        cs_n;
	logic        wr_n;
	logic [1:0]  addr;
	logic [7:0]  din;
	wire  [7:0]  dout;
	wire         irq_n;
	logic [9:0]  value_a;
	logic [7:0]  value_b;
	logic        mark_a;
	logic        mark_b;
	logic        flags_off;
	int          check_count;
	int          error_count;
	int          cycle_count = 0;

	always #20 clk_int = ~clk_int;

	fm_timer_core #(
		.PRESCALE    (PRESCALE),
		.BUSY_CYCLES (BUSY_CYCLES)
	) dut (
		.clk_int (clk_int),
		.arst_n  (arst_n),
		.cs_n    (cs_n),
		.wr_n    (wr_n),
		.addr    (addr),
		.din     (din),
		.dout    (dout),
		.irq_n   (irq_n)
	);

	fm_timer_checker #(
		.PRESCALE    (PRESCALE),
		.BUSY_CYCLES (BUSY_CYCLES)
	) u_checker (
		.clk_int     (clk_int),
		.arst_n      (arst_n),
		.cs_n        (cs_n),
		.wr_n        (wr_n),
		.addr        (addr),
		.dout        (dout),
		.irq_n       (irq_n),
		.value_a     (value_a),
		.value_b     (value_b),
		.mark_a      (mark_a),
		.mark_b      (mark_b),
		.flags_off   (flags_off),
		.check_count (check_count),
		.error_count (error_count)
	);

	// One strobe, then one idle cycle; called on a falling edge
	task automatic bus_cycle(input logic [1:0] a, input logic [7:0] d, input logic [1:0] mark);
		addr   = a;
		din    = d;
		cs_n   = 1'b0;
		wr_n   = 1'b0;
		mark_a = mark[0];
		mark_b = mark[1];
		@(negedge clk_int);
		cs_n   = 1'b1;
		wr_n   = 1'b1;
		mark_a = 1'b0;
		mark_b = 1'b0;
		@(negedge clk_int);
	endtask

	task automatic wait_ready();
		while (dout[7]) begin
			@(negedge clk_int);
		end
	endtask

	// Returns once busy has reached dout
	task automatic write_reg(input logic [7:0] num, input logic [7:0] data,
			input logic [1:0] mark);
		wait_ready();
		bus_cycle(2'd0, num, 2'b00);
		wait_ready();
		bus_cycle(2'd1, data, mark);
		repeat (3) @(negedge clk_int);
	endtask

	task automatic write_ctrl(input logic [7:0] ctrl);
		write_reg(fm_pkg::REG_TCTRL, ctrl, 2'b00);
		wait_ready();
	endtask

	task automatic wait_flag(input int idx);
		while (!dout[idx]) begin
			@(negedge clk_int);
		end
	endtask

	always @(posedge clk_int) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, a flag or busy never settled", cycle_count);
			$display("Checks: %0d, errors: %0d", check_count, error_count);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(94387));
		arst_n    = 1'b0;
		cs_n      = 1'b1;
		wr_n      = 1'b1;
		addr      = 2'd0;
		din       = 8'h00;
		mark_a    = 1'b0;
		mark_b    = 1'b0;
		flags_off = 1'b0;
		value_a   = '0;
		value_b   = '0;
		repeat (16) @(negedge clk_int);
		arst_n = 1'b1;
		repeat (2) @(negedge clk_int);

		// Timer A, with a second upper byte sent while busy
		value_a = 10'($urandom % 1000);
		write_reg(fm_pkg::REG_TA_HIGH, value_a[9:2], 2'b00);
		bus_cycle(2'd1, ~value_a[9:2], 2'b00);
		write_reg(fm_pkg::REG_TA_LOW, {6'b0, value_a[1:0]}, 2'b00);
		write_reg(fm_pkg::REG_TCTRL, 8'h05, 2'b01);
		repeat (3) begin
			wait_flag(0);
			write_ctrl(8'h15);
		end
		write_ctrl(8'h10);

		// Timer B
		value_b = 8'($urandom % 256);
		write_reg(fm_pkg::REG_TB, value_b, 2'b00);
		write_reg(fm_pkg::REG_TCTRL, 8'h0A, 2'b10);
		repeat (3) begin
			wait_flag(1);
			write_ctrl(8'h2A);
		end
		write_ctrl(8'h20);

		// Flag reset, then Timer A running with its flag disabled
		write_reg(fm_pkg::REG_TCTRL, 8'h05, 2'b01);
		wait_flag(0);
		write_ctrl(8'h11);
		flags_off = 1'b1;
		repeat (2 * (1024 - int'(value_a)) * PRESCALE) @(negedge clk_int);
		flags_off = 1'b0;

		repeat (4) @(negedge clk_int);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0 && check_count > 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* fm_timer_core.f */
source/fm_pkg.sv
source/fm_bus_port.sv
source/fm_write_sequencer.sv
source/fm_reg_map.sv
source/fm_prescaler.sv
source/fm_timers.sv
source/fm_timer_core.sv
test/fm_timer_checker.sv
test/fm_timer_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing -Wno-fatal --top-module fm_timer_core_tb \
	-f fm_timer_core.f -o fm_timer_core_sim > build.log 2>&1 \
	&& ./obj_dir/fm_timer_core_sim > sim.log 2>&1 \
	|| echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
